//--- dv/mpmem_assertions.sv
`timescale 1ns/1ps

module mpmem_assertions (
  input logic                               clk,
  input logic                               arst_n,
  input logic                               ready,
  input logic [mpmem_pkg::num_wrpt-1:0]     write,
  input logic [mpmem_pkg::addr_width-1:0]   wr_addr0,
  input logic [mpmem_pkg::addr_width-1:0]   wr_addr1,
  input logic [mpmem_pkg::num_rdpt-1:0]     read,
  input logic [mpmem_pkg::num_rdpt-1:0]     rd_vld
);

  int                             fail_cnt = 0;
  logic [mpmem_pkg::num_rdpt-1:0] accepted;
  logic                           conflict;

  assign accepted = read & {mpmem_pkg::num_rdpt{ready}};
  assign conflict = ready && (write == 2'b11) &&
                    (wr_addr0[mpmem_pkg::addr_width-1:1] != wr_addr1[mpmem_pkg::addr_width-1:1]);

  // --------------------------------------------------
  // Read timing on both ports
  // --------------------------------------------------
  rd_lat0: assert property (@(posedge clk) disable iff (!arst_n)
    accepted[0] |-> ##2 rd_vld[0])
  else begin
    fail_cnt++;
    $error("Read on port 0 not returned two cycles after acceptance");
  end

  rd_lat1: assert property (@(posedge clk) disable iff (!arst_n)
    accepted[1] |-> ##2 rd_vld[1])
  else begin
    fail_cnt++;
    $error("Read on port 1 not returned two cycles after acceptance");
  end

  rd_src0: assert property (@(posedge clk) disable iff (!arst_n)
    rd_vld[0] |-> $past(accepted[0], 2))
  else begin
    fail_cnt++;
    $error("rd_vld[0] high without a read accepted two cycles earlier");
  end

  rd_src1: assert property (@(posedge clk) disable iff (!arst_n)
    rd_vld[1] |-> $past(accepted[1], 2))
  else begin
    fail_cnt++;
    $error("rd_vld[1] high without a read accepted two cycles earlier");
  end

  // Pending write drains in one cycle while ready is low
  drain_stall: assert property (@(posedge clk) disable iff (!arst_n)
    conflict |=> !ready ##1 ready)
  else begin
    fail_cnt++;
    $error("Ready not low for exactly one cycle after a row conflict");
  end

endmodule

bind mpmem_top mpmem_assertions u_assertions (
  .clk      (clk),
  .arst_n   (arst_n),
  .ready    (ready),
  .write    (write),
  .wr_addr0 (wr_addr0),
  .wr_addr1 (wr_addr1),
  .read     (read),
  .rd_vld   (rd_vld)
);

//--- dv/mpmem_checker.sv
`timescale 1ns/1ps

module mpmem_checker (
  input  logic                               clk,
  input  logic                               arst_n,
  input  logic                               ready,
  input  logic [mpmem_pkg::num_wrpt-1:0]     write,
  input  logic [mpmem_pkg::addr_width-1:0]   wr_addr0,
  input  logic [mpmem_pkg::addr_width-1:0]   wr_addr1,
  input  logic [mpmem_pkg::num_rdpt-1:0]     read,
  input  logic [mpmem_pkg::word_width-1:0]   exp_word0,
  input  logic [mpmem_pkg::word_width-1:0]   exp_word1,
  input  logic [mpmem_pkg::num_rdpt-1:0]     rd_vld,
  input  logic [mpmem_pkg::word_width-1:0]   rd_dout0,
  input  logic [mpmem_pkg::word_width-1:0]   rd_dout1,
  output int                                 checks,
  output int                                 errors,
  output logic                               idle
);

  logic [mpmem_pkg::word_width-1:0] exp_q0 [$];
  logic [mpmem_pkg::word_width-1:0] exp_q1 [$];
  logic                             same_row_q;

  task automatic compare_word(input int port, input logic [mpmem_pkg::word_width-1:0] got);
    logic [mpmem_pkg::word_width-1:0] exp;
    int                               depth;
    depth = (port == 0) ? exp_q0.size() : exp_q1.size();
    if (depth == 0) begin
      errors++;
      $display("rd_vld[%0d] went high with no read outstanding", port);
    end else begin
      if (port == 0) begin
        exp = exp_q0.pop_front();
      end else begin
        exp = exp_q1.pop_front();
      end
      checks++;
      if (got !== exp) begin
        errors++;
        $display("Fail rd_dout%0d: got %h expected %h", port, got, exp);
      end
    end
  endtask

  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      exp_q0.delete();
      exp_q1.delete();
      checks     = 0;
      errors     = 0;
      same_row_q = 1'b0;
      idle       = 1'b1;
    end else begin
      if (rd_vld[0]) compare_word(0, rd_dout0);
      if (rd_vld[1]) compare_word(1, rd_dout1);
      // Combined row write must not stall
      if (same_row_q && !ready) begin
        errors++;
        $display("Fail ready: got %h expected %h after a same-row write pair", ready, 1'b1);
      end
      same_row_q = ready && (write == 2'b11) &&
                   (wr_addr0[mpmem_pkg::addr_width-1:1] == wr_addr1[mpmem_pkg::addr_width-1:1]);
      if (ready && read[0]) exp_q0.push_back(exp_word0);
      if (ready && read[1]) exp_q1.push_back(exp_word1);
      idle = (exp_q0.size() == 0) && (exp_q1.size() == 0);
    end
  end

endmodule

//--- dv/mpmem_golden.txt
# test wr0 wa0 d0 wr1 wa1 d1 rd0 ra0 rd1 ra1 exp0 exp1
# All fields hex except test. exp is the word read back, 0000 when the port is idle
1 0 00 0000 0 00 0000 1 00 1 01 0000 0000
1 0 00 0000 0 00 0000 1 02 1 03 0000 0000
1 0 00 0000 0 00 0000 1 0e 1 0f 0000 0000
1 0 00 0000 0 00 0000 1 10 1 11 0000 0000
1 0 00 0000 0 00 0000 1 1e 1 1f 0000 0000
1 0 00 0000 0 00 0000 1 20 1 21 0000 0000
1 0 00 0000 0 00 0000 1 3c 1 3d 0000 0000
1 0 00 0000 0 00 0000 1 3e 1 3f 0000 0000
2 1 04 a1b2 0 00 0000 0 00 0 00 0000 0000
2 0 00 0000 1 09 3c4d 0 00 0 00 0000 0000
2 0 00 0000 0 00 0000 1 04 1 04 a1b2 a1b2
2 0 00 0000 0 00 0000 1 09 1 09 3c4d 3c4d
2 1 0a 1357 0 00 0000 1 04 1 09 a1b2 3c4d
2 0 00 0000 0 00 0000 1 0a 1 0b 1357 0000
3 1 12 5a5a 1 13 a5a5 0 00 0 00 0000 0000
3 0 00 0000 0 00 0000 1 12 1 13 5a5a a5a5
3 0 00 0000 0 00 0000 1 13 1 12 a5a5 5a5a
3 1 15 0f0f 1 14 f0f0 0 00 0 00 0000 0000
3 0 00 0000 0 00 0000 1 14 1 15 f0f0 0f0f
4 1 20 1111 1 20 2222 0 00 0 00 0000 0000
4 0 00 0000 0 00 0000 1 20 1 21 2222 0000
4 1 3f dead 1 3f beef 1 3f 1 20 0000 2222
4 0 00 0000 0 00 0000 1 3f 1 3f beef beef
5 1 06 cafe 1 30 f00d 1 06 1 30 0000 0000
5 0 00 0000 0 00 0000 1 30 1 06 f00d cafe
5 1 07 0102 1 08 0304 0 00 0 00 0000 0000
5 0 00 0000 0 00 0000 1 06 1 07 cafe 0102
5 0 00 0000 0 00 0000 1 08 1 09 0304 3c4d
6 1 04 7777 0 00 0000 1 04 1 04 a1b2 a1b2
6 0 00 0000 1 04 8888 1 04 1 04 7777 7777
6 0 00 0000 0 00 0000 1 04 1 13 8888 a5a5
6 0 00 0000 0 00 0000 1 12 1 14 5a5a f0f0
6 0 00 0000 0 00 0000 1 20 1 3f 2222 beef
6 0 00 0000 0 00 0000 1 00 1 30 0000 f00d

//--- dv/mpmem_tb.sv
`timescale 1ns/1ps

module mpmem_tb;

  localparam int max_lines    = 64;
  localparam int reset_cycles = 16;

  typedef struct packed {
    logic [7:0]  test;
    logic [1:0]  write;
    logic [5:0]  wr_addr0;
    logic [5:0]  wr_addr1;
    logic [15:0] din0;
    logic [15:0] din1;
    logic [1:0]  read;
    logic [5:0]  rd_addr0;
    logic [5:0]  rd_addr1;
    logic [15:0] exp0;
    logic [15:0] exp1;
  } line_t;

  logic                               clk;
  logic                               arst_n;
  logic [mpmem_pkg::num_wrpt-1:0]     write;
  logic [mpmem_pkg::addr_width-1:0]   wr_addr0;
  logic [mpmem_pkg::addr_width-1:0]   wr_addr1;
  logic [mpmem_pkg::word_width-1:0]   din0;
  logic [mpmem_pkg::word_width-1:0]   din1;
  logic [mpmem_pkg::num_rdpt-1:0]     read;
  logic [mpmem_pkg::addr_width-1:0]   rd_addr0;
  logic [mpmem_pkg::addr_width-1:0]   rd_addr1;
  logic                               ready;
  logic [mpmem_pkg::num_rdpt-1:0]     rd_vld;
  logic [mpmem_pkg::word_width-1:0]   rd_dout0;
  logic [mpmem_pkg::word_width-1:0]   rd_dout1;
  logic [mpmem_pkg::word_width-1:0]   exp_word0;
  logic [mpmem_pkg::word_width-1:0]   exp_word1;
  int                                 checks;
  int                                 errors;
  logic                               idle;
  line_t                              lines [max_lines];
  int                                 n_lines = 0;
  int                                 tb_errors = 0;
  int                                 seed;
  logic                               loaded = 1'b0;

  initial clk = 1'b0;
  always #10 clk = ~clk;

  mpmem_top dut (
    .clk(clk), .arst_n(arst_n), .write(write), .wr_addr0(wr_addr0), .wr_addr1(wr_addr1),
    .din0(din0), .din1(din1), .read(read), .rd_addr0(rd_addr0), .rd_addr1(rd_addr1),
    .ready(ready), .rd_vld(rd_vld), .rd_dout0(rd_dout0), .rd_dout1(rd_dout1)
  );

  mpmem_checker u_checker (
    .clk(clk), .arst_n(arst_n), .ready(ready), .write(write), .wr_addr0(wr_addr0),
    .wr_addr1(wr_addr1), .read(read), .exp_word0(exp_word0), .exp_word1(exp_word1),
    .rd_vld(rd_vld), .rd_dout0(rd_dout0), .rd_dout1(rd_dout1),
    .checks(checks), .errors(errors), .idle(idle)
  );

  function automatic int total_errors();
    return errors + tb_errors + dut.u_assertions.fail_cnt;
  endfunction

  // --------------------------------------------------
  // Golden file and driver
  // --------------------------------------------------
  task automatic load_golden();
    int          fd;
    int          t;
    string       text;
    logic [15:0] v [12];
    fd = $fopen("dv/mpmem_golden.txt", "r");
    if (fd == 0) begin
      tb_errors++;
      $display("Could not open dv/mpmem_golden.txt");
    end else begin
      while (!$feof(fd) && n_lines < max_lines) begin
        text = "";
        void'($fgets(text, fd));
        // Comment and blank lines do not parse
        if ($sscanf(text, "%d %h %h %h %h %h %h %h %h %h %h %h %h", t, v[0], v[1], v[2],
                    v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10], v[11]) == 13) begin
          lines[n_lines] = {t[7:0], v[3][0], v[0][0], v[1][5:0], v[4][5:0], v[2], v[5],
                            v[8][0], v[6][0], v[7][5:0], v[9][5:0], v[10], v[11]};
          n_lines++;
        end
      end
      $fclose(fd);
      if (n_lines == 0) begin
        tb_errors++;
        $display("No stimulus lines found in dv/mpmem_golden.txt");
      end
    end
  endtask

  task automatic apply_line(input line_t l);
    write     = l.write;
    wr_addr0  = l.wr_addr0;
    wr_addr1  = l.wr_addr1;
    din0      = l.din0;
    din1      = l.din1;
    read      = l.read;
    rd_addr0  = l.rd_addr0;
    rd_addr1  = l.rd_addr1;
    exp_word0 = l.exp0;
    exp_word1 = l.exp1;
  endtask

  task automatic finish_test(input int test, inout int c0, inout int e0);
    while (!idle) begin
      @(posedge clk);
      #1;
    end
    $display("test %0d finished: %0d reads checked, %0d errors", test, checks - c0,
             total_errors() - e0);
    c0 = checks;
    e0 = total_errors();
  endtask

  initial begin : main
    int gap;
    int rise;
    int cur_test;
    int c0;
    int e0;
    int n_tests;
    seed = 32'h8e68_c542;
    arst_n = 1'b0;
    apply_line('0);
    load_golden();
    loaded = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #1 arst_n = 1'b1;
    @(posedge clk);                 // First edge out of reset
    rise = 0;
    do begin
      @(posedge clk);
      rise++;
      #1;
    end while (!ready);
    if (rise != 1 + mpmem_pkg::init_cycles) begin
      tb_errors++;
      $display("Fail ready rise cycles: got %h expected %h", rise,
               1 + mpmem_pkg::init_cycles);
    end
    c0 = 0;
    e0 = 0;
    n_tests = 0;
    cur_test = (n_lines > 0) ? int'(lines[0].test) : 0;
    for (int i = 0; i < n_lines; i++) begin
      if (int'(lines[i].test) != cur_test) begin
        finish_test(cur_test, c0, e0);
        n_tests++;
        cur_test = lines[i].test;
      end
      apply_line(lines[i]);
      while (!ready) begin          // Hold the request through a stall
        @(posedge clk);
        #1;
      end
      @(posedge clk);
      #1;
      write = '0;
      read  = '0;
      gap = $random(seed) & 3;
      if (gap == 3) gap = 0;        // Mostly back-to-back
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
    end
    if (n_lines > 0) begin
      finish_test(cur_test, c0, e0);
      n_tests++;
    end
    $display("%0d tests, %0d reads checked, %0d errors", n_tests, checks, total_errors());
    if (total_errors() == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Watchdog sized from the number of golden lines
  initial begin : watchdog
    int limit;
    wait (loaded);
    limit = reset_cycles + 2 + mpmem_pkg::init_cycles + 2 + 40 * n_lines;
    repeat (limit) @(posedge clk);
    $display("Timeout: the run did not finish within %0d clock cycles", limit);
    $display("Test failed");
    $finish;
  end

endmodule

//--- logic/mpmem_bank.sv
`timescale 1ns/1ps

module mpmem_bank (
  input  logic                               clk,
  input  logic                               mem_write,
  input  logic [mpmem_pkg::row_width-1:0]    mem_wrow,
  input  logic [mpmem_pkg::num_lane-1:0]     mem_lane_en,
  input  logic [mpmem_pkg::phy_width-1:0]    mem_wdata,
  input  logic                               mem_read,
  input  logic [mpmem_pkg::row_width-1:0]    mem_rrow,
  output logic [mpmem_pkg::phy_width-1:0]    mem_rdata
);

  logic [mpmem_pkg::phy_width-1:0] mem [mpmem_pkg::num_row];

  // Lane-wise write
  always_ff @(posedge clk) begin
    for (int l = 0; l < mpmem_pkg::num_lane; l++) begin
      if (mem_write && mem_lane_en[l]) begin
        mem[mem_wrow][l*mpmem_pkg::word_width +: mpmem_pkg::word_width] <=
          mem_wdata[l*mpmem_pkg::word_width +: mpmem_pkg::word_width];
      end
    end
  end

  // Registered read returns old data on a same-row write
  always_ff @(posedge clk) begin
    if (mem_read) begin
      mem_rdata <= mem[mem_rrow];
    end
  end

endmodule

//--- logic/mpmem_ctrl.sv
`timescale 1ns/1ps

module mpmem_ctrl (
  input  logic                                clk,
  input  logic                                arst_n,
  input  logic [mpmem_pkg::num_wrpt-1:0]      write,
  input  logic [mpmem_pkg::addr_width-1:0]    wr_addr0,
  input  logic [mpmem_pkg::addr_width-1:0]    wr_addr1,
  input  logic [mpmem_pkg::word_width-1:0]    din0,
  input  logic [mpmem_pkg::word_width-1:0]    din1,
  output logic                                ready,
  output logic                                mem_write,
  output logic [mpmem_pkg::row_width-1:0]     mem_wrow,
  output logic [mpmem_pkg::num_lane-1:0]      mem_lane_en,
  output logic [mpmem_pkg::phy_width-1:0]     mem_wdata
);

  logic                               rst_meta;
  logic                               rst_sync;
  mpmem_pkg::ctrl_state_e             state;
  mpmem_pkg::ctrl_state_e             state_nxt;
  logic [mpmem_pkg::row_width-1:0]    sweep_row;
  logic                               wr0;
  logic                               wr1;
  logic [mpmem_pkg::row_width-1:0]    row0;
  logic [mpmem_pkg::row_width-1:0]    row1;
  logic                               lane0;
  logic                               lane1;
  logic                               conflict;
  logic [mpmem_pkg::row_width-1:0]    pend_row;
  logic                               pend_lane;
  logic [mpmem_pkg::word_width-1:0]   pend_data;

  // --------------------------------------------------
  // Reset synchroniser
  // --------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rst_meta <= 1'b0;
      rst_sync <= 1'b0;
    end else begin
      rst_meta <= 1'b1;
      rst_sync <= rst_meta;   // Sweep starts once this is high
    end
  end

  assign ready = (state == mpmem_pkg::st_run);

  // Accepted writes split into row and lane
  assign wr0      = write[0] & ready;
  assign wr1      = write[1] & ready;
  assign row0     = wr_addr0[mpmem_pkg::addr_width-1:1];
  assign row1     = wr_addr1[mpmem_pkg::addr_width-1:1];
  assign lane0    = wr_addr0[0];
  assign lane1    = wr_addr1[0];
  assign conflict = wr0 & wr1 & (row0 != row1);

  // --------------------------------------------------
  // Write combiner
  // --------------------------------------------------
  always_comb begin
    mem_write   = 1'b0;
    mem_wrow    = '0;
    mem_lane_en = '0;
    mem_wdata   = '0;
    case (state)
      mpmem_pkg::st_init: begin
        mem_write   = rst_sync;
        mem_wrow    = sweep_row;
        mem_lane_en = '1;       // Whole row to zero
      end
      mpmem_pkg::st_drain: begin
        mem_write              = 1'b1;
        mem_wrow               = pend_row;
        mem_lane_en[pend_lane] = 1'b1;
        mem_wdata              = {mpmem_pkg::num_lane{pend_data}};
      end
      default: begin
        mem_write = wr0 | wr1;
        mem_wrow  = (wr1 && !conflict) ? row1 : row0;
        for (int l = 0; l < mpmem_pkg::num_lane; l++) begin
          // Port 1 checked first so it wins a shared lane
          if (wr1 && !conflict && lane1 == l) begin
            mem_lane_en[l] = 1'b1;
            mem_wdata[l*mpmem_pkg::word_width +: mpmem_pkg::word_width] = din1;
          end else if (wr0 && lane0 == l) begin
            mem_lane_en[l] = 1'b1;
            mem_wdata[l*mpmem_pkg::word_width +: mpmem_pkg::word_width] = din0;
          end
        end
      end
    endcase
  end

  // --------------------------------------------------
  // State and sweep counter
  // --------------------------------------------------
  always_comb begin
    state_nxt = state;
    case (state)
      mpmem_pkg::st_init: begin
        if (rst_sync &&
            sweep_row == mpmem_pkg::row_width'(mpmem_pkg::init_cycles - 1)) begin
          state_nxt = mpmem_pkg::st_run;
        end
      end
      mpmem_pkg::st_run: begin
        if (conflict) begin
          state_nxt = mpmem_pkg::st_drain;
        end
      end
      mpmem_pkg::st_drain: state_nxt = mpmem_pkg::st_run;   // Single cycle
      default:             state_nxt = mpmem_pkg::st_init;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= mpmem_pkg::st_init;
      sweep_row <= '0;
    end else begin
      state <= state_nxt;
      if (state == mpmem_pkg::st_init && rst_sync) begin
        sweep_row <= sweep_row + 1'b1;
      end
    end
  end

  // Port 1 parked on a row conflict
  always_ff @(posedge clk) begin
    if (conflict) begin
      pend_row  <= row1;
      pend_lane <= lane1;
      pend_data <= din1;
    end
  end

endmodule

//--- logic/mpmem_pkg.sv
package mpmem_pkg;

  // --------------------------------------------------
  // Logical view
  // --------------------------------------------------
  localparam int word_width = 16;
  localparam int num_wrpt   = 2;
  localparam int num_rdpt   = 2;
  localparam int num_addr   = 64;
  localparam int addr_width = $clog2(num_addr);

  // --------------------------------------------------
  // Physical view
  // --------------------------------------------------
  localparam int num_lane    = 2;             // Words per row picked by addr bit 0
  localparam int num_row     = num_addr / num_lane;
  localparam int row_width   = $clog2(num_row);
  localparam int phy_width   = num_lane * word_width;
  localparam int init_cycles = num_row;       // One row cleared per cycle

  // Controller state
  typedef enum logic [1:0] {
    st_init,   // Sweep clears rows
    st_run,
    st_drain   // Parked port 1 write goes out
  } ctrl_state_e;

endpackage

//--- logic/mpmem_rd_port.sv
`timescale 1ns/1ps

module mpmem_rd_port (
  input  logic                               clk,
  input  logic                               arst_n,
  input  logic                               read_en,    // Already qualified by ready
  input  logic [mpmem_pkg::addr_width-1:0]   rd_addr,
  output logic                               mem_read,
  output logic [mpmem_pkg::row_width-1:0]    mem_rrow,
  input  logic [mpmem_pkg::phy_width-1:0]    mem_rdata,
  output logic                               rd_vld,
  output logic [mpmem_pkg::word_width-1:0]   rd_dout
);

  logic lane_q;
  logic vld_q;

  // Bank samples the row at the accepting edge, before that cycle's write lands
  assign mem_read = read_en;
  assign mem_rrow = rd_addr[mpmem_pkg::addr_width-1:1];

  // --------------------------------------------------
  // Valid pipeline
  // --------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      vld_q  <= 1'b0;
      rd_vld <= 1'b0;
    end else begin
      vld_q  <= read_en;
      rd_vld <= vld_q;
    end
  end

  // Lane bit follows the bank access
  always_ff @(posedge clk) begin
    if (read_en) begin
      lane_q <= rd_addr[0];
    end
  end

  // Lane select into the output register
  always_ff @(posedge clk) begin
    if (vld_q) begin
      rd_dout <= mem_rdata[lane_q*mpmem_pkg::word_width +: mpmem_pkg::word_width];
    end
  end

endmodule

//--- logic/mpmem_top.sv
`timescale 1ns/1ps

module mpmem_top (
  input  logic                               clk,
  input  logic                               arst_n,
  input  logic [mpmem_pkg::num_wrpt-1:0]     write,
  input  logic [mpmem_pkg::addr_width-1:0]   wr_addr0,
  input  logic [mpmem_pkg::addr_width-1:0]   wr_addr1,
  input  logic [mpmem_pkg::word_width-1:0]   din0,
  input  logic [mpmem_pkg::word_width-1:0]   din1,
  input  logic [mpmem_pkg::num_rdpt-1:0]     read,
  input  logic [mpmem_pkg::addr_width-1:0]   rd_addr0,
  input  logic [mpmem_pkg::addr_width-1:0]   rd_addr1,
  output logic                               ready,
  output logic [mpmem_pkg::num_rdpt-1:0]     rd_vld,
  output logic [mpmem_pkg::word_width-1:0]   rd_dout0,
  output logic [mpmem_pkg::word_width-1:0]   rd_dout1
);

  logic                              mem_write;
  logic [mpmem_pkg::row_width-1:0]   mem_wrow;
  logic [mpmem_pkg::num_lane-1:0]    mem_lane_en;
  logic [mpmem_pkg::phy_width-1:0]   mem_wdata;
  logic [mpmem_pkg::num_rdpt-1:0]    read_en;
  logic [mpmem_pkg::num_rdpt-1:0]    mem_read;
  logic [mpmem_pkg::row_width-1:0]   mem_rrow0;
  logic [mpmem_pkg::row_width-1:0]   mem_rrow1;
  logic [mpmem_pkg::phy_width-1:0]   mem_rdata0;
  logic [mpmem_pkg::phy_width-1:0]   mem_rdata1;

  assign read_en = read & {mpmem_pkg::num_rdpt{ready}};

  // --------------------------------------------------
  // Combine and write
  // --------------------------------------------------
  mpmem_ctrl u_ctrl (
    .clk         (clk),
    .arst_n      (arst_n),
    .write       (write),
    .wr_addr0    (wr_addr0),
    .wr_addr1    (wr_addr1),
    .din0        (din0),
    .din1        (din1),
    .ready       (ready),
    .mem_write   (mem_write),
    .mem_wrow    (mem_wrow),
    .mem_lane_en (mem_lane_en),
    .mem_wdata   (mem_wdata)
  );

  // --------------------------------------------------
  // One bank replica per read port
  // --------------------------------------------------
  mpmem_bank u_bank0 (
    .clk         (clk),
    .mem_write   (mem_write),
    .mem_wrow    (mem_wrow),
    .mem_lane_en (mem_lane_en),
    .mem_wdata   (mem_wdata),
    .mem_read    (mem_read[0]),
    .mem_rrow    (mem_rrow0),
    .mem_rdata   (mem_rdata0)
  );

  mpmem_bank u_bank1 (
    .clk         (clk),
    .mem_write   (mem_write),
    .mem_wrow    (mem_wrow),
    .mem_lane_en (mem_lane_en),
    .mem_wdata   (mem_wdata),
    .mem_read    (mem_read[1]),
    .mem_rrow    (mem_rrow1),
    .mem_rdata   (mem_rdata1)
  );

  mpmem_rd_port u_rd_port0 (
    .clk       (clk),
    .arst_n    (arst_n),
    .read_en   (read_en[0]),
    .rd_addr   (rd_addr0),
    .mem_read  (mem_read[0]),
    .mem_rrow  (mem_rrow0),
    .mem_rdata (mem_rdata0),
    .rd_vld    (rd_vld[0]),
    .rd_dout   (rd_dout0)
  );

  mpmem_rd_port u_rd_port1 (
    .clk       (clk),
    .arst_n    (arst_n),
    .read_en   (read_en[1]),
    .rd_addr   (rd_addr1),
    .mem_read  (mem_read[1]),
    .mem_rrow  (mem_rrow1),
    .mem_rdata (mem_rdata1),
    .rd_vld    (rd_vld[1]),
    .rd_dout   (rd_dout1)
  );

endmodule

//--- mpmem.f
logic/mpmem_pkg.sv
logic/mpmem_ctrl.sv
logic/mpmem_bank.sv
logic/mpmem_rd_port.sv
logic/mpmem_top.sv
dv/mpmem_assertions.sv
dv/mpmem_checker.sv
dv/mpmem_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the mpmem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module mpmem_tb -Mdir obj_dir -f mpmem.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vmpmem_tb +verilator+error+limit+100)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Test passed"; then
  exit 0
fi
exit 1
